//--- common/apu_config.svh
`ifndef APU_CONFIG_SVH
`define APU_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Subsystem sizing
////////////////////////////////////////////////////////////////////////////

// Architectural registers in the register file
`define APU_NUM_REGS 32

// Register index width, log2 of the register count
`define APU_REG_AW 5

// Operand and result width
`define APU_DATA_W 32

// Pipeline depth, one 8-bit multiplier slice per stage
`define APU_NUM_STAGES 4

`endif

//--- common/apu_op_pkg.sv
`include "apu_config.svh"

package apu_op_pkg;

  // Operation code carried down the pipeline
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_LI  = 3'd2,
    OP_SLL = 3'd3,
    OP_MUL = 3'd4
  } apu_op_e;

  // Latency class as seen by the dispatcher
  typedef enum logic [1:0] {
    LAT_1     = 2'd1,
    LAT_2     = 2'd2,
    LAT_MULTI = 2'd3
  } apu_lat_e;

  // Multiplier slice of operand B handled by each stage
  localparam int unsigned SLICE_W = 8;

  // Shift amount bits done in stage 0, the rest in stage 1
  localparam int unsigned SHAMT_LO_W = 4;

  function automatic apu_lat_e lat_of(apu_op_e op);
    case (op)
      OP_SLL:  return LAT_2;
      OP_MUL:  return LAT_MULTI;
      default: return LAT_1;
    endcase
  endfunction

  // Stage after which an item of the given class leaves
  function automatic int unsigned exit_stage(apu_lat_e lat);
    case (lat)
      LAT_2:     return 1;
      LAT_MULTI: return `APU_NUM_STAGES - 1;
      default:   return 0;
    endcase
  endfunction

endpackage

//--- common/apu_instr_pkg.sv
`include "apu_config.svh"

package apu_instr_pkg;

  localparam int unsigned INSTR_W = 32;
  localparam int unsigned IMM_W   = 19;

  // Register view, three register fields
  typedef struct packed {
    apu_op_pkg::apu_op_e     opcode;
    logic [`APU_REG_AW-1:0]  rd;
    logic [`APU_REG_AW-1:0]  rs1;
    logic [`APU_REG_AW-1:0]  rs2;
    logic [13:0]             unused;
  } apu_instr_reg_t;

  // Immediate view, rs2 and the spare bits form a signed immediate
  typedef struct packed {
    apu_op_pkg::apu_op_e     opcode;
    logic [`APU_REG_AW-1:0]  rd;
    logic [`APU_REG_AW-1:0]  rs1;
    logic [IMM_W-1:0]        imm;
  } apu_instr_imm_t;

  // One instruction word, decoded by opcode
  typedef union packed {
    apu_instr_reg_t reg_v;
    apu_instr_imm_t imm_v;
  } apu_instr_u;

  function automatic logic [`APU_DATA_W-1:0] imm_sext(apu_instr_u instr);
    return {{(`APU_DATA_W-IMM_W){instr.imm_v.imm[IMM_W-1]}}, instr.imm_v.imm};
  endfunction

endpackage

//--- hw/apu_disp/apu_disp.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module apu_disp (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Request from issue
  input  logic                             enable_i,
  input  apu_op_pkg::apu_lat_e             apu_lat_i,
  input  logic [`APU_REG_AW-1:0]           apu_waddr_i,

  // Destination of the oldest outstanding result
  output logic [`APU_REG_AW-1:0]           apu_waddr_o,
  output logic                             apu_multicycle_o,
  output logic                             apu_singlecycle_o,

  output logic                             active_o,
  output logic                             stall_o,

  // Dependency checks against the decoding instruction
  input  logic                             is_decoding_i,
  input  logic [1:0][`APU_REG_AW-1:0]      read_regs_i,
  input  logic [1:0]                       read_regs_valid_i,
  output logic                             read_dep_o,
  input  logic [`APU_REG_AW-1:0]           write_regs_i,
  input  logic                             write_regs_valid_i,
  output logic                             write_dep_o,

  // Performance events
  output logic                             perf_type_o,
  output logic                             perf_cont_o,

  // Pipeline handshake
  output logic                             apu_req_o,
  input  logic                             apu_gnt_i,
  input  logic                             apu_rvalid_i
);

  logic [`APU_REG_AW-1:0] addr_inflight, addr_waiting;
  logic [`APU_REG_AW-1:0] addr_inflight_d, addr_waiting_d;
  logic                   valid_inflight, valid_waiting;
  logic                   valid_inflight_d, valid_waiting_d;
  logic                   valid_req, req_accepted, active;
  logic                   returned_req, returned_inflight, returned_waiting;
  logic                   stall_full, stall_type, stall_nack;
  logic [1:0]             rdep_inflight, rdep_waiting;
  logic                   wdep_inflight, wdep_waiting;
  apu_op_pkg::apu_lat_e   apu_lat;

  // No request while full or on a class conflict, a nack keeps it up
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & apu_gnt_i;

  // Results come back in order, the waiting slot is always the older
  assign returned_req      = valid_req & apu_rvalid_i & ~valid_inflight & ~valid_waiting;
  assign returned_inflight = valid_inflight & apu_rvalid_i & ~valid_waiting;
  assign returned_waiting  = valid_waiting & apu_rvalid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding slots
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight <= 1'b0;
      valid_waiting  <= 1'b0;
      addr_inflight  <= '0;
      addr_waiting   <= '0;
    end else begin
      valid_inflight <= valid_inflight_d;
      valid_waiting  <= valid_waiting_d;
      addr_inflight  <= addr_inflight_d;
      addr_waiting   <= addr_waiting_d;
    end
  end

  always_comb begin
    valid_inflight_d = valid_inflight;
    valid_waiting_d  = valid_waiting;
    addr_inflight_d  = addr_inflight;
    addr_waiting_d   = addr_waiting;
    if (req_accepted && !returned_req) begin
      // New item always enters the in-flight slot
      valid_inflight_d = 1'b1;
      addr_inflight_d  = apu_waddr_i;
      // Older in-flight item moves down, or refills a retiring waiting slot
      if ((valid_inflight && !returned_inflight) || returned_waiting) begin
        valid_waiting_d = 1'b1;
        addr_waiting_d  = addr_inflight;
      end
    end else if (returned_inflight) begin
      valid_inflight_d = 1'b0;
      valid_waiting_d  = 1'b0;
      addr_inflight_d  = '0;
      addr_waiting_d   = '0;
    end else if (returned_waiting) begin
      valid_waiting_d = 1'b0;
      addr_waiting_d  = '0;
    end
  end

  assign active = valid_inflight | valid_waiting;

  // Class of the most recent request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      apu_lat <= apu_op_pkg::LAT_1;
    end else if (valid_req) begin
      apu_lat <= apu_lat_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Dependency checks
  ////////////////////////////////////////////////////////////////////////////

  // Decoding instruction is the requester itself, so only slots are compared
  for (genvar i = 0; i < 2; i++) begin : gen_read_deps
    assign rdep_inflight[i] = (read_regs_i[i] == addr_inflight) & read_regs_valid_i[i];
    assign rdep_waiting[i]  = (read_regs_i[i] == addr_waiting) & read_regs_valid_i[i];
  end

  assign wdep_inflight = (write_regs_i == addr_inflight) & write_regs_valid_i;
  assign wdep_waiting  = (write_regs_i == addr_waiting) & write_regs_valid_i;

  // A slot returning this cycle no longer blocks, the RF writes through
  assign read_dep_o  = is_decoding_i &
                       ((|rdep_inflight & valid_inflight & ~returned_inflight) |
                        (|rdep_waiting & valid_waiting & ~returned_waiting));
  assign write_dep_o = is_decoding_i &
                       ((wdep_inflight & valid_inflight & ~returned_inflight) |
                        (wdep_waiting & valid_waiting & ~returned_waiting));

  ////////////////////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////////////////////

  // Both slots taken
  assign stall_full = valid_inflight & valid_waiting;
  // While active only a class 2 may follow, and never behind a multicycle item
  assign stall_type = enable_i & active &
                      ((apu_lat_i == apu_op_pkg::LAT_1) |
                       ((apu_lat_i == apu_op_pkg::LAT_2) & (apu_lat == apu_op_pkg::LAT_MULTI)) |
                       (apu_lat_i == apu_op_pkg::LAT_MULTI));
  // Pipeline frozen by back-pressure
  assign stall_nack = valid_req & ~apu_gnt_i;
  assign stall_o    = stall_full | stall_type | stall_nack;

  assign apu_req_o = valid_req;

  // Oldest outstanding destination, stable while a result waits for ready
  always_comb begin
    if (valid_waiting) begin
      apu_waddr_o = addr_waiting;
    end else if (valid_inflight) begin
      apu_waddr_o = addr_inflight;
    end else begin
      apu_waddr_o = apu_waddr_i;
    end
  end

  assign active_o          = active;
  assign perf_type_o       = stall_type;
  assign perf_cont_o       = stall_nack;
  assign apu_multicycle_o  = (apu_lat == apu_op_pkg::LAT_MULTI);
  assign apu_singlecycle_o = ~active;

endmodule

//--- hw/apu_issue.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module apu_issue (
  input  logic                            clk_i,
  input  logic                            rst_ni,

  // Instruction intake
  input  logic                            instr_valid_i,
  input  apu_instr_pkg::apu_instr_u       instr_i,
  output logic                            instr_ready_o,

  // Dispatcher side
  input  logic                            stall_i,
  input  logic                            read_dep_i,
  input  logic                            write_dep_i,
  input  logic                            req_i,
  input  logic                            gnt_i,
  output logic                            enable_o,
  output apu_op_pkg::apu_lat_e            lat_o,
  output logic [`APU_REG_AW-1:0]          rd_o,
  output logic                            is_decoding_o,
  output logic [1:0][`APU_REG_AW-1:0]     rs_o,
  output logic [1:0]                      rs_valid_o,
  output logic                            rd_valid_o,

  // Payload into stage 0
  output apu_op_pkg::apu_op_e             op_o,
  output logic [`APU_DATA_W-1:0]          opa_o,
  output logic [`APU_DATA_W-1:0]          opb_o,

  // Register file write from the drain
  input  logic                            rf_we_i,
  input  logic [`APU_REG_AW-1:0]          rf_waddr_i,
  input  logic [`APU_DATA_W-1:0]          rf_wdata_i
);

  apu_instr_pkg::apu_instr_u  dec_q;
  logic                       dec_valid_q;
  logic                       out_of_reset_q;
  logic                       dec_fire;
  logic                       is_li;
  logic [`APU_DATA_W-1:0]     rf_q [`APU_NUM_REGS];
  logic [`APU_DATA_W-1:0]     rs1_val, rs2_val;

  ////////////////////////////////////////////////////////////////////////////
  // Decode register
  ////////////////////////////////////////////////////////////////////////////

  // Ready only once out of reset and while decode is empty
  assign instr_ready_o = out_of_reset_q & ~dec_valid_q;

  // Request accepted and no stall pending
  assign dec_fire = req_i & gnt_i & ~stall_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_of_reset_q <= 1'b0;
      dec_valid_q    <= 1'b0;
    end else begin
      out_of_reset_q <= 1'b1;
      if (instr_valid_i && instr_ready_o) begin
        dec_valid_q <= 1'b1;
      end else if (dec_fire) begin
        dec_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      dec_q <= instr_i;
    end
  end

  // Opcode, rd and rs1 sit at the same place in both views
  assign op_o  = dec_q.reg_v.opcode;
  assign is_li = (op_o == apu_op_pkg::OP_LI);

  assign rd_o          = dec_q.reg_v.rd;
  assign rs_o[0]       = dec_q.reg_v.rs1;
  assign rs_o[1]       = dec_q.reg_v.rs2;
  assign rs_valid_o    = (dec_valid_q && !is_li) ? 2'b11 : 2'b00;
  assign rd_valid_o    = dec_valid_q;
  assign is_decoding_o = dec_valid_q;
  assign lat_o         = apu_op_pkg::lat_of(op_o);

  // Hold back while a source or the destination is still outstanding
  assign enable_o = dec_valid_q & ~read_dep_i & ~write_dep_i;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `APU_NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rf_we_i) begin
      rf_q[rf_waddr_i] <= rf_wdata_i;
    end
  end

  // Write-through read, a result retiring this cycle is seen at once
  always_comb begin
    rs1_val = rf_q[rs_o[0]];
    rs2_val = rf_q[rs_o[1]];
    if (rf_we_i && (rf_waddr_i == rs_o[0])) begin
      rs1_val = rf_wdata_i;
    end
    if (rf_we_i && (rf_waddr_i == rs_o[1])) begin
      rs2_val = rf_wdata_i;
    end
  end

  // LI takes its value from the immediate view
  assign opa_o = is_li ? '0 : rs1_val;
  assign opb_o = is_li ? apu_instr_pkg::imm_sext(dec_q) : rs2_val;

endmodule

//--- hw/apu_pipe/apu_stage.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module apu_stage #(
  parameter int unsigned STAGE_IDX = 0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   freeze_i,

  // From the previous stage, or from issue for stage 0
  input  logic                   valid_i,
  input  apu_op_pkg::apu_op_e    op_i,
  input  logic [`APU_DATA_W-1:0] a_i,
  input  logic [`APU_DATA_W-1:0] b_i,
  input  logic [`APU_DATA_W-1:0] acc_i,

  // To the next stage
  output logic                   valid_o,
  output apu_op_pkg::apu_op_e    op_o,
  output logic [`APU_DATA_W-1:0] a_o,
  output logic [`APU_DATA_W-1:0] b_o,
  output logic [`APU_DATA_W-1:0] acc_o,

  // Held item leaves here
  output logic                   exit_o
);

  localparam int unsigned SLICE_LSB = apu_op_pkg::SLICE_W * STAGE_IDX;

  logic [`APU_DATA_W-1:0]  acc_d;
  logic [`APU_DATA_W-1:0]  b_slice;
  logic                    valid_q;
  logic                    exit_here;

  // This stage's 8-bit multiplier slice, zero extended
  assign b_slice = {{(`APU_DATA_W-apu_op_pkg::SLICE_W){1'b0}},
                    b_i[SLICE_LSB +: apu_op_pkg::SLICE_W]};

  always_comb begin
    acc_d = acc_i;
    case (op_i)
      apu_op_pkg::OP_ADD: if (STAGE_IDX == 0) acc_d = a_i + b_i;
      apu_op_pkg::OP_SUB: if (STAGE_IDX == 0) acc_d = a_i - b_i;
      apu_op_pkg::OP_LI:  if (STAGE_IDX == 0) acc_d = b_i;
      apu_op_pkg::OP_SLL: begin
        // Low shift bits first, bit 4 finishes the shift in stage 1
        if (STAGE_IDX == 0) begin
          acc_d = a_i << b_i[apu_op_pkg::SHAMT_LO_W-1:0];
        end else if (STAGE_IDX == 1) begin
          acc_d = acc_i << {b_i[apu_op_pkg::SHAMT_LO_W], 4'b0000};
        end
      end
      // Partial product of A with this slice, placed at its weight
      apu_op_pkg::OP_MUL: acc_d = acc_i + ((a_i * b_slice) << SLICE_LSB);
      default: acc_d = acc_i;
    endcase
  end

  // Everything holds while the drain waits for ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (!freeze_i) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!freeze_i) begin
      op_o  <= op_i;
      a_o   <= a_i;
      b_o   <= b_i;
      acc_o <= acc_d;
    end
  end

  assign exit_here = (apu_op_pkg::exit_stage(apu_op_pkg::lat_of(op_o)) == STAGE_IDX);

  // An item that leaves here is not passed on
  assign exit_o  = valid_q & exit_here;
  assign valid_o = valid_q & ~exit_here;

endmodule

//--- hw/apu_pipe/apu_drain.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module apu_drain (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,

  // Leaving flags and results of every stage
  input  logic [`APU_NUM_STAGES-1:0]                 exit_i,
  input  logic [`APU_NUM_STAGES-1:0][`APU_DATA_W-1:0] acc_i,

  input  logic                                       wb_ready_i,
  input  logic [`APU_REG_AW-1:0]                     waddr_i,

  // Pipeline control and dispatcher return
  output logic                                       freeze_o,
  output logic                                       gnt_o,
  output logic                                       rvalid_o,

  // Result port
  output logic                                       wb_valid_o,
  output logic [`APU_REG_AW-1:0]                     wb_addr_o,
  output logic [`APU_DATA_W-1:0]                     wb_data_o,

  // Register file write
  output logic                                       rf_we_o,
  output logic [`APU_REG_AW-1:0]                     rf_waddr_o,
  output logic [`APU_DATA_W-1:0]                     rf_wdata_o
);

  logic [`APU_DATA_W-1:0] sel_data;

  // One-hot mux over the stages
  always_comb begin
    sel_data = '0;
    for (int s = 0; s < `APU_NUM_STAGES; s++) begin
      sel_data |= acc_i[s] & {`APU_DATA_W{exit_i[s]}};
    end
  end

  assign wb_valid_o = |exit_i;
  assign wb_data_o  = sel_data;
  // Destination tracked by the dispatcher for the oldest item
  assign wb_addr_o  = waddr_i;

  // Leaving result not taken, hold the whole pipeline
  assign freeze_o = wb_valid_o & ~wb_ready_i;
  assign gnt_o    = ~freeze_o;

  // Handshake retires the result
  assign rvalid_o   = wb_valid_o & wb_ready_i;
  assign rf_we_o    = rvalid_o;
  assign rf_waddr_o = waddr_i;
  assign rf_wdata_o = sel_data;

  // Class stall keeps exits apart, two at once would lose a result
  a_single_exit: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(exit_i))
    else $error("more than one stage leaving in the same cycle");

endmodule

//--- hw/apu_subsys_top.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module apu_subsys_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 instr_valid_i,
  input  logic [apu_instr_pkg::INSTR_W-1:0]    instr_i,
  output logic                                 instr_ready_o,
  output logic                                 wb_valid_o,
  output logic [`APU_REG_AW-1:0]               wb_addr_o,
  output logic [`APU_DATA_W-1:0]               wb_data_o,
  input  logic                                 wb_ready_i,
  output logic                                 active_o,
  output logic                                 perf_type_o,
  output logic                                 perf_cont_o
);

  logic                              enable, stall, read_dep, write_dep;
  logic                              is_decoding, rd_valid, req, gnt, rvalid, freeze;
  apu_op_pkg::apu_lat_e              lat;
  logic [`APU_REG_AW-1:0]            rd, waddr, rf_waddr;
  logic [1:0][`APU_REG_AW-1:0]       rs;
  logic [1:0]                        rs_valid;
  logic                              rf_we;
  logic [`APU_DATA_W-1:0]            rf_wdata;

  // Stage chain, index 0 is the issue payload
  logic [`APU_NUM_STAGES:0]                   valid_w;
  apu_op_pkg::apu_op_e                        op_w [`APU_NUM_STAGES+1];
  logic [`APU_NUM_STAGES:0][`APU_DATA_W-1:0]  a_w, b_w, acc_w;
  logic [`APU_NUM_STAGES-1:0]                 exit_w;

  // Stage 0 loads on request, gated by freeze which is the inverted grant
  assign valid_w[0] = req;
  assign acc_w[0]   = '0;

  apu_issue issue_inst (
    .clk_i, .rst_ni, .instr_valid_i, .instr_i, .instr_ready_o,
    .stall_i(stall), .read_dep_i(read_dep), .write_dep_i(write_dep),
    .req_i(req), .gnt_i(gnt), .enable_o(enable), .lat_o(lat), .rd_o(rd),
    .is_decoding_o(is_decoding), .rs_o(rs), .rs_valid_o(rs_valid), .rd_valid_o(rd_valid),
    .op_o(op_w[0]), .opa_o(a_w[0]), .opb_o(b_w[0]),
    .rf_we_i(rf_we), .rf_waddr_i(rf_waddr), .rf_wdata_i(rf_wdata)
  );

  apu_disp disp_inst (
    .clk_i, .rst_ni, .enable_i(enable), .apu_lat_i(lat), .apu_waddr_i(rd),
    .apu_waddr_o(waddr), .apu_multicycle_o(), .apu_singlecycle_o(),
    .active_o, .stall_o(stall), .is_decoding_i(is_decoding),
    .read_regs_i(rs), .read_regs_valid_i(rs_valid), .read_dep_o(read_dep),
    .write_regs_i(rd), .write_regs_valid_i(rd_valid), .write_dep_o(write_dep),
    .perf_type_o, .perf_cont_o, .apu_req_o(req), .apu_gnt_i(gnt), .apu_rvalid_i(rvalid)
  );

  for (genvar g = 0; g < `APU_NUM_STAGES; g++) begin : gen_stage
    apu_stage #(.STAGE_IDX(g)) stage_inst (
      .clk_i, .rst_ni, .freeze_i(freeze),
      .valid_i(valid_w[g]), .op_i(op_w[g]), .a_i(a_w[g]), .b_i(b_w[g]), .acc_i(acc_w[g]),
      .valid_o(valid_w[g+1]), .op_o(op_w[g+1]), .a_o(a_w[g+1]), .b_o(b_w[g+1]),
      .acc_o(acc_w[g+1]), .exit_o(exit_w[g])
    );
  end

  apu_drain drain_inst (
    .clk_i, .rst_ni, .exit_i(exit_w), .acc_i(acc_w[`APU_NUM_STAGES:1]),
    .wb_ready_i, .waddr_i(waddr), .freeze_o(freeze), .gnt_o(gnt), .rvalid_o(rvalid),
    .wb_valid_o, .wb_addr_o, .wb_data_o,
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata)
  );

endmodule

//--- verification/apu_subsys_props.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module apu_subsys_props (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_ready_i,
  input  logic                   wb_valid_i,
  input  logic                   wb_ready_i,
  input  logic [`APU_REG_AW-1:0] wb_addr_i,
  input  logic [`APU_DATA_W-1:0] wb_data_i,
  input  logic                   req_i,
  input  logic                   perf_cont_i
);

  // Count of failed properties
  int unsigned fail_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Result port protocol
  ////////////////////////////////////////////////////////////////////////////

  // A waiting result keeps valid, address and data until taken
  a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_i && !wb_ready_i |=> wb_valid_i && $stable(wb_addr_i) && $stable(wb_data_i))
    else begin
      fail_count++;
      $error("result port changed while waiting for ready");
    end

  // Second reset cycle onward, flops have settled to their reset state
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni ##1 !rst_ni |-> !instr_ready_i && !wb_valid_i)
    else begin
      fail_count++;
      $error("ready or result valid raised during reset");
    end

  // Back-pressure on a pending request shows up as a nack stall
  a_nack_counted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_i && !wb_ready_i && req_i |-> perf_cont_i)
    else begin
      fail_count++;
      $error("blocked request not counted as contention");
    end

endmodule

//--- verification/tb_apu_subsys.sv
`timescale 1ns/1ps
`include "apu_config.svh"

module tb_apu_subsys;

  localparam int unsigned SEED             = 32'h3692_94d6;
  localparam int unsigned CYCLES_PER_INSTR = 40;
  localparam int unsigned IDLE_LIMIT       = 200;
  localparam int unsigned ENTRY_W          = `APU_REG_AW + `APU_DATA_W;

  logic                   clk_i = 1'b0;
  logic                   rst_ni = 1'b0;
  logic                   instr_valid_i;
  logic [31:0]            instr_i;
  logic                   instr_ready_o;
  logic                   wb_valid_o;
  logic [`APU_REG_AW-1:0] wb_addr_o;
  logic [`APU_DATA_W-1:0] wb_data_o;
  logic                   wb_ready_i;
  logic                   active_o;
  logic                   perf_type_o;
  logic                   perf_cont_o;

  // Reference model, register values and results in issue order
  logic [`APU_DATA_W-1:0] model_regs [`APU_NUM_REGS];
  logic [31:0]            prog_q [$];
  logic [ENTRY_W-1:0]     exp_q [$];
  logic                   saw_type_stall;

  always #2 clk_i = ~clk_i;

  apu_subsys_top apu_subsys_top_inst (
    .clk_i, .rst_ni, .instr_valid_i, .instr_i, .instr_ready_o,
    .wb_valid_o, .wb_addr_o, .wb_data_o, .wb_ready_i,
    .active_o, .perf_type_o, .perf_cont_o
  );

  bind apu_subsys_top apu_subsys_props props_inst (
    .clk_i, .rst_ni, .instr_ready_i(instr_ready_o), .wb_valid_i(wb_valid_o),
    .wb_ready_i, .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
    .req_i(req), .perf_cont_i(perf_cont_o)
  );

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  // Bound protocol checks end the run as soon as one fires
  always @(negedge clk_i) begin
    if (apu_subsys_top_inst.props_inst.fail_count != 0) begin
      $display("A bound protocol assertion failed at %0t", $time);
      stop_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoding and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic push_reg(input apu_op_pkg::apu_op_e op, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
    prog_q.push_back({op, rd, rs1, rs2, 14'b0});
  endtask

  task automatic push_li(input logic [4:0] rd, input logic [18:0] imm);
    prog_q.push_back({apu_op_pkg::OP_LI, rd, 5'd0, imm});
  endtask

  // Executes one word in program order and queues its result
  task automatic model_commit(input logic [31:0] word);
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    rd = word[28:24];
    a  = model_regs[word[23:19]];
    b  = model_regs[word[18:14]];
    case (word[31:29])
      apu_op_pkg::OP_ADD: res = a + b;
      apu_op_pkg::OP_SUB: res = a - b;
      apu_op_pkg::OP_LI:  res = {{13{word[18]}}, word[18:0]};
      apu_op_pkg::OP_SLL: res = a << b[4:0];
      apu_op_pkg::OP_MUL: res = a * b;
      default:            res = '0;
    endcase
    model_regs[rd] = res;
    exp_q.push_back({rd, res});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per-cycle driver and result check
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_result();
    logic [ENTRY_W-1:0] entry;
    if (exp_q.size() == 0) begin
      $display("Unexpected result for r%0d at %0t with nothing outstanding", wb_addr_o, $time);
      stop_run();
    end else begin
      entry = exp_q.pop_front();
      assert (wb_addr_o == entry[ENTRY_W-1:`APU_DATA_W]) else begin
        $display("Mismatch at %0t: wb_addr_o expected %0d, got %0d",
                 $time, entry[ENTRY_W-1:`APU_DATA_W], wb_addr_o);
        stop_run();
      end
      assert (wb_data_o == entry[`APU_DATA_W-1:0]) else begin
        $display("Mismatch at %0t: wb_data_o expected 0x%08h, got 0x%08h",
                 $time, entry[`APU_DATA_W-1:0], wb_data_o);
        stop_run();
      end
    end
  endtask

  // Outputs are sampled first, then the inputs for this cycle are driven
  task automatic step_cycle(input int unsigned ready_pct, input int unsigned send_pct);
    logic rdy;
    logic send;
    @(negedge clk_i);
    if (perf_type_o) begin
      saw_type_stall = 1'b1;
    end
    // A presented result is still outstanding in the dispatcher
    assert (!wb_valid_o || active_o) else begin
      $display("Result presented at %0t while active_o was low", $time);
      stop_run();
    end
    rdy  = ($urandom_range(99) < ready_pct);
    send = (prog_q.size() != 0) && instr_ready_o && ($urandom_range(99) < send_pct);
    // Handshake completes at the next rising edge
    if (wb_valid_o && rdy) begin
      check_result();
    end
    wb_ready_i = rdy;
    if (send) begin
      instr_i = prog_q.pop_front();
      model_commit(instr_i);
      instr_valid_i = 1'b1;
    end else begin
      instr_valid_i = 1'b0;
      instr_i       = '0;
    end
  endtask

  task automatic run_program(input int unsigned ready_pct, input int unsigned send_pct);
    int unsigned cycles;
    int unsigned limit;
    cycles = 0;
    limit  = 100 + CYCLES_PER_INSTR * prog_q.size();
    while (prog_q.size() != 0 || exp_q.size() != 0) begin
      if (cycles == limit) begin
        $display("Timeout at %0t with %0d instructions unsent and %0d results missing",
                 $time, prog_q.size(), exp_q.size());
        stop_run();
      end else begin
        step_cycle(ready_pct, send_pct);
        cycles++;
      end
    end
  endtask

  task automatic wait_idle();
    int unsigned cycles;
    logic        done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      if (cycles == IDLE_LIMIT) begin
        $display("Timeout at %0t waiting for the subsystem to go idle", $time);
        stop_run();
      end else begin
        step_cycle(100, 0);
        done = !active_o && !wb_valid_o;
        cycles++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    wb_ready_i     = 1'b0;
    saw_type_stall = 1'b0;
    for (int r = 0; r < `APU_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    // Nothing outstanding out of reset
    assert (!active_o) else begin
      $display("active_o high at %0t while in reset", $time);
      stop_run();
    end
    rst_ni = 1'b1;

    // Loads, then add and subtract with wrap-around
    push_li(5'd1, 19'd1234);
    push_li(5'd2, -19'sd77);
    push_li(5'd7, 19'h3ffff);
    push_reg(apu_op_pkg::OP_ADD, 5'd4, 5'd1, 5'd2);
    push_reg(apu_op_pkg::OP_SUB, 5'd6, 5'd2, 5'd1);
    push_reg(apu_op_pkg::OP_MUL, 5'd8, 5'd7, 5'd7);
    push_reg(apu_op_pkg::OP_ADD, 5'd9, 5'd8, 5'd8);
    push_reg(apu_op_pkg::OP_SUB, 5'd3, 5'd0, 5'd9);
    run_program(100, 100);

    // Shift pairs, then a multiply feeding an add
    push_li(5'd10, 19'd3);
    push_li(5'd11, 19'd5);
    push_li(5'd15, 19'd17);
    push_reg(apu_op_pkg::OP_SLL, 5'd12, 5'd11, 5'd10);
    push_reg(apu_op_pkg::OP_SLL, 5'd13, 5'd12, 5'd10);
    push_reg(apu_op_pkg::OP_SLL, 5'd14, 5'd11, 5'd10);
    push_reg(apu_op_pkg::OP_SLL, 5'd16, 5'd11, 5'd15);
    push_reg(apu_op_pkg::OP_MUL, 5'd17, 5'd12, 5'd16);
    push_reg(apu_op_pkg::OP_ADD, 5'd18, 5'd17, 5'd11);
    run_program(100, 100);

    // Same destination twice, last writer wins
    push_reg(apu_op_pkg::OP_MUL, 5'd5, 5'd7, 5'd11);
    push_li(5'd5, -19'sd5);
    push_reg(apu_op_pkg::OP_ADD, 5'd20, 5'd5, 5'd0);
    run_program(100, 100);

    // Short classes right behind longer ones
    push_reg(apu_op_pkg::OP_MUL, 5'd21, 5'd7, 5'd10);
    push_reg(apu_op_pkg::OP_ADD, 5'd22, 5'd1, 5'd2);
    push_reg(apu_op_pkg::OP_SLL, 5'd23, 5'd11, 5'd10);
    push_reg(apu_op_pkg::OP_SUB, 5'd24, 5'd2, 5'd1);
    push_reg(apu_op_pkg::OP_MUL, 5'd25, 5'd1, 5'd11);
    push_reg(apu_op_pkg::OP_SLL, 5'd26, 5'd25, 5'd10);
    run_program(100, 100);
    assert (saw_type_stall) else begin
      $display("perf_type_o never rose although class conflicts were issued");
      stop_run();
    end

    // Random stream under random back-pressure and gaps
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(4) == 2) begin
        push_li(5'($urandom_range(31, 1)), 19'($urandom()));
      end else begin
        push_reg(apu_op_pkg::apu_op_e'(($urandom_range(3) == 2) ? 4 : $urandom_range(3)),
                 5'($urandom_range(31, 1)), 5'($urandom_range(31)), 5'($urandom_range(31)));
      end
    end
    run_program(60, 70);

    wait_idle();
    if (apu_subsys_top_inst.props_inst.fail_count != 0) begin
      $display("Regression failed");
      $fatal(1, "protocol assertion failed");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- sim.f
+incdir+common
common/apu_op_pkg.sv
common/apu_instr_pkg.sv
hw/apu_disp/apu_disp.sv
hw/apu_issue.sv
hw/apu_pipe/apu_stage.sv
hw/apu_pipe/apu_drain.sv
hw/apu_subsys_top.sv
verification/apu_subsys_props.sv
verification/tb_apu_subsys.sv
